// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP = tb_ddr3_test
FILELIST = compile.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
logic/ddr3_test_pkg.sv
logic/ip_rom.sv
logic/ip_ram.sv
logic/ip_console.sv
logic/ip_init_status.sv
logic/ddr3_test_top.sv
sim/tb_ddr3_test.sv

// File: logic/ddr3_test_pkg.sv
// address map, I/O port numbers and timing for the memory-test bus subsystem
// referenced by scoped name from the logic and the testbench
package ddr3_test_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// memory regions are picked by address bits 15:13
	localparam int TAG_LSB = 13;
	localparam logic [2:0] ROM_BASE_TAG = 3'd0;
	localparam logic [2:0] RAM_BASE_TAG = 3'd2;

	// scratch RAM, 0x4000 to 0x5FFF
	localparam int RAM_DEPTH = 8192;
	localparam int RAM_AW = $clog2(RAM_DEPTH);

	// I/O ports, matched against the low address byte
	localparam logic [7:0] PORT_CON_DATA = 8'h10;
	localparam logic [7:0] PORT_CON_STAT = 8'h11;
	localparam logic [7:0] PORT_INIT_STAT = 8'h30;

	// modelled DDR3 init time after reset release, in clk cycles
	localparam int INIT_CYCLES = 64;
	localparam int INIT_CNT_W = $clog2(INIT_CYCLES + 1);

endpackage

// File: logic/ddr3_test_top.sv
// bus subsystem top: ROM, RAM, console and DDR3 init status on one byte bus
// each responder decodes its own region, their read returns are ORed together
`timescale 1ns/10ps

module ddr3_test_top (
	input  logic                             reset_n,
	input  logic                             clk,
	input  logic [ddr3_test_pkg::ADDR_W-1:0] bus_address,
	input  logic                             bus_memreq,
	input  logic                             bus_valid,
	input  logic                             bus_write,
	input  logic [ddr3_test_pkg::DATA_W-1:0] bus_wdata,
	input  logic [ddr3_test_pkg::DATA_W-1:0] con_rx_data,
	input  logic                             con_rx_valid,
	output logic                             bus_ready,
	output logic [ddr3_test_pkg::DATA_W-1:0] bus_rdata,
	output logic                             bus_rdata_en,
	output logic [ddr3_test_pkg::DATA_W-1:0] con_tx_data,
	output logic                             con_tx_valid
);

	logic [ddr3_test_pkg::DATA_W-1:0] rom_rdata;
	logic [ddr3_test_pkg::DATA_W-1:0] ram_rdata;
	logic [ddr3_test_pkg::DATA_W-1:0] con_rdata;
	logic [ddr3_test_pkg::DATA_W-1:0] init_rdata;
	logic                             rom_rdata_en;
	logic                             ram_rdata_en;
	logic                             con_rdata_en;
	logic                             init_rdata_en;

	ip_rom ip_rom_inst (
		.reset_n      (reset_n),
		.clk          (clk),
		.bus_address  (bus_address),
		.bus_memreq   (bus_memreq),
		.bus_valid    (bus_valid),
		.bus_write    (bus_write),
		.rom_rdata    (rom_rdata),
		.rom_rdata_en (rom_rdata_en)
	);

	ip_ram ip_ram_inst (
		.reset_n      (reset_n),
		.clk          (clk),
		.bus_address  (bus_address),
		.bus_memreq   (bus_memreq),
		.bus_valid    (bus_valid),
		.bus_write    (bus_write),
		.bus_wdata    (bus_wdata),
		.ram_rdata    (ram_rdata),
		.ram_rdata_en (ram_rdata_en)
	);

	ip_console ip_console_inst (
		.reset_n      (reset_n),
		.clk          (clk),
		.bus_address  (bus_address),
		.bus_memreq   (bus_memreq),
		.bus_valid    (bus_valid),
		.bus_write    (bus_write),
		.bus_wdata    (bus_wdata),
		.con_rx_data  (con_rx_data),
		.con_rx_valid (con_rx_valid),
		.con_tx_data  (con_tx_data),
		.con_tx_valid (con_tx_valid),
		.con_rdata    (con_rdata),
		.con_rdata_en (con_rdata_en)
	);

	ip_init_status ip_init_status_inst (
		.reset_n       (reset_n),
		.clk           (clk),
		.bus_address   (bus_address),
		.bus_memreq    (bus_memreq),
		.bus_valid     (bus_valid),
		.bus_write     (bus_write),
		.init_rdata    (init_rdata),
		.init_rdata_en (init_rdata_en)
	);

	// no wait states on this bus
	assign bus_ready = 1'b1;

	// idle responders drive zero, so a plain OR merges the returns
	assign bus_rdata = rom_rdata | ram_rdata | con_rdata | init_rdata;
	assign bus_rdata_en = rom_rdata_en | ram_rdata_en | con_rdata_en | init_rdata_en;

	// address decodes must never overlap
	a_one_responder: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0({rom_rdata_en, ram_rdata_en, con_rdata_en, init_rdata_en}));

endmodule

// File: logic/ip_console.sv
// console byte ports: 0x10 sends and receives whole bytes, 0x11 reports rx_full
// tx leaves as a one-cycle strobe, rx is latched from the con_rx_valid strobe
`timescale 1ns/10ps

module ip_console (
	input  logic                             reset_n,
	input  logic                             clk,
	input  logic [ddr3_test_pkg::ADDR_W-1:0] bus_address,
	input  logic                             bus_memreq,
	input  logic                             bus_valid,
	input  logic                             bus_write,
	input  logic [ddr3_test_pkg::DATA_W-1:0] bus_wdata,
	input  logic [ddr3_test_pkg::DATA_W-1:0] con_rx_data,
	input  logic                             con_rx_valid,
	output logic [ddr3_test_pkg::DATA_W-1:0] con_tx_data,
	output logic                             con_tx_valid,
	output logic [ddr3_test_pkg::DATA_W-1:0] con_rdata,
	output logic                             con_rdata_en
);

	logic                             io_req;
	logic                             data_sel;
	logic                             stat_sel;
	logic                             data_wr;
	logic                             data_rd;
	logic                             stat_rd;
	logic [ddr3_test_pkg::DATA_W-1:0] rx_byte;
	logic                             rx_full;

	assign io_req = bus_valid && !bus_memreq;
	assign data_sel = io_req && (bus_address[7:0] == ddr3_test_pkg::PORT_CON_DATA);
	assign stat_sel = io_req && (bus_address[7:0] == ddr3_test_pkg::PORT_CON_STAT);
	assign data_wr = data_sel && bus_write;
	assign data_rd = data_sel && !bus_write;
	assign stat_rd = stat_sel && !bus_write;

	// transmit side
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			con_tx_valid <= 1'b0;
		end else begin
			con_tx_valid <= data_wr;
		end
		if (data_wr) begin
			con_tx_data <= bus_wdata;
		end
	end

	// receive latch, a new strobe beats a read of the data port
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rx_full <= 1'b0;
		end else if (con_rx_valid) begin
			rx_full <= 1'b1;
		end else if (data_rd) begin
			rx_full <= 1'b0;
		end
		if (con_rx_valid) begin
			rx_byte <= con_rx_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			con_rdata <= '0;
			con_rdata_en <= 1'b0;
		end else if (data_rd) begin
			con_rdata <= rx_byte;
			con_rdata_en <= 1'b1;
		end else if (stat_rd) begin
			con_rdata <= {{(ddr3_test_pkg::DATA_W-1){1'b0}}, rx_full};
			con_rdata_en <= 1'b1;
		end else begin
			con_rdata <= '0;
			con_rdata_en <= 1'b0;
		end
	end

	// the latch only captures a known byte with each strobe
	a_rx_data_known: assert property (@(posedge clk) disable iff (!reset_n)
		con_rx_valid |-> !$isunknown(con_rx_data));

endmodule

// File: logic/ip_init_status.sv
// stands in for the DDR3 controller init-busy flag polled by the boot program
// port 0x30 reads 1 until INIT_CYCLES cycles have passed since reset release
`timescale 1ns/10ps

module ip_init_status (
	input  logic                             reset_n,
	input  logic                             clk,
	input  logic [ddr3_test_pkg::ADDR_W-1:0] bus_address,
	input  logic                             bus_memreq,
	input  logic                             bus_valid,
	input  logic                             bus_write,
	output logic [ddr3_test_pkg::DATA_W-1:0] init_rdata,
	output logic                             init_rdata_en
);

	localparam logic [ddr3_test_pkg::INIT_CNT_W-1:0] CNT_DONE =
		ddr3_test_pkg::INIT_CNT_W'(ddr3_test_pkg::INIT_CYCLES);

	logic [ddr3_test_pkg::INIT_CNT_W-1:0] init_cnt;
	logic                                 busy;
	logic                                 rd_hit;

	assign busy = init_cnt < CNT_DONE;
	assign rd_hit = bus_valid && !bus_memreq && !bus_write
		&& (bus_address[7:0] == ddr3_test_pkg::PORT_INIT_STAT);

	// saturates once init is done
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			init_cnt <= '0;
		end else if (busy) begin
			init_cnt <= init_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			init_rdata <= '0;
			init_rdata_en <= 1'b0;
		end else if (rd_hit) begin
			init_rdata <= {{(ddr3_test_pkg::DATA_W-1){1'b0}}, busy};
			init_rdata_en <= 1'b1;
		end else begin
			init_rdata <= '0;
			init_rdata_en <= 1'b0;
		end
	end

endmodule

// File: logic/ip_ram.sv
// 8 KB scratch RAM at 0x4000, written at the request edge
// reads return the stored byte one cycle after the request
`timescale 1ns/10ps

module ip_ram (
	input  logic                             reset_n,
	input  logic                             clk,
	input  logic [ddr3_test_pkg::ADDR_W-1:0] bus_address,
	input  logic                             bus_memreq,
	input  logic                             bus_valid,
	input  logic                             bus_write,
	input  logic [ddr3_test_pkg::DATA_W-1:0] bus_wdata,
	output logic [ddr3_test_pkg::DATA_W-1:0] ram_rdata,
	output logic                             ram_rdata_en
);

	logic [ddr3_test_pkg::DATA_W-1:0] mem [0:ddr3_test_pkg::RAM_DEPTH-1];
	logic [ddr3_test_pkg::DATA_W-1:0] rd_q;
	logic [ddr3_test_pkg::RAM_AW-1:0] idx;
	logic                             ram_sel;
	logic                             wr_hit;
	logic                             rd_hit;

	assign idx = bus_address[ddr3_test_pkg::RAM_AW-1:0];
	assign ram_sel = bus_valid && bus_memreq
		&& (bus_address[ddr3_test_pkg::ADDR_W-1:ddr3_test_pkg::TAG_LSB]
		== ddr3_test_pkg::RAM_BASE_TAG);
	assign wr_hit = ram_sel && bus_write;
	assign rd_hit = ram_sel && !bus_write;

	// plain synchronous array, read port registered every cycle
	always_ff @(posedge clk) begin
		if (wr_hit) begin
			mem[idx] <= bus_wdata;
		end
		rd_q <= mem[idx];
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ram_rdata_en <= 1'b0;
		end else begin
			ram_rdata_en <= rd_hit;
		end
	end

	assign ram_rdata = ram_rdata_en ? rd_q : '0;

endmodule

// File: logic/ip_rom.sv
// boot ROM holding the memory-test program, answers memory reads in the low 8 KB
// the byte comes back one cycle after the request, with rom_rdata_en high
`timescale 1ns/10ps

module ip_rom (
	input  logic                             reset_n,
	input  logic                             clk,
	input  logic [ddr3_test_pkg::ADDR_W-1:0] bus_address,
	input  logic                             bus_memreq,
	input  logic                             bus_valid,
	input  logic                             bus_write,
	output logic [ddr3_test_pkg::DATA_W-1:0] rom_rdata,
	output logic                             rom_rdata_en
);

	logic rd_hit;

	// program image, anything past the last byte reads as zero
	function automatic logic [ddr3_test_pkg::DATA_W-1:0] rom_byte(
		input logic [ddr3_test_pkg::TAG_LSB-1:0] offset
	);
		case (offset)
			0: rom_byte = 8'hF3;
			1: rom_byte = 8'h31;
			2: rom_byte = 8'h00;
			3: rom_byte = 8'h40;
			4: rom_byte = 8'hCD;
			5: rom_byte = 8'h59;
			6: rom_byte = 8'h00;
			7: rom_byte = 8'h11;
			8: rom_byte = 8'h24;
			9: rom_byte = 8'h00;
			10: rom_byte = 8'hCD;
			11: rom_byte = 8'h6B;
			12: rom_byte = 8'h00;
			13: rom_byte = 8'hCD;
			14: rom_byte = 8'h59;
			15: rom_byte = 8'h00;
			16: rom_byte = 8'h11;
			17: rom_byte = 8'h3E;
			18: rom_byte = 8'h00;
			19: rom_byte = 8'hCD;
			20: rom_byte = 8'h6B;
			21: rom_byte = 8'h00;
			// init poll loop on port 0x30
			22: rom_byte = 8'hDB;
			23: rom_byte = 8'h30;
			24: rom_byte = 8'hB7;
			25: rom_byte = 8'h20;
			26: rom_byte = 8'hFB;
			27: rom_byte = 8'h11;
			28: rom_byte = 8'h54;
			29: rom_byte = 8'h00;
			30: rom_byte = 8'hCD;
			31: rom_byte = 8'h6B;
			32: rom_byte = 8'h00;
			33: rom_byte = 8'hC3;
			34: rom_byte = 8'h07;
			35: rom_byte = 8'h00;
			// banner and message strings
			36: rom_byte = 8'h44;
			37: rom_byte = 8'h44;
			38: rom_byte = 8'h52;
			39: rom_byte = 8'h33;
			40: rom_byte = 8'h2D;
			41: rom_byte = 8'h53;
			42: rom_byte = 8'h44;
			43: rom_byte = 8'h52;
			44: rom_byte = 8'h41;
			45: rom_byte = 8'h4D;
			46: rom_byte = 8'h20;
			47: rom_byte = 8'h54;
			48: rom_byte = 8'h65;
			49: rom_byte = 8'h73;
			50: rom_byte = 8'h74;
			51: rom_byte = 8'h20;
			52: rom_byte = 8'h70;
			53: rom_byte = 8'h72;
			54: rom_byte = 8'h6F;
			55: rom_byte = 8'h67;
			56: rom_byte = 8'h72;
			57: rom_byte = 8'h61;
			58: rom_byte = 8'h6D;
			59: rom_byte = 8'h0D;
			60: rom_byte = 8'h0A;
			61: rom_byte = 8'h00;
			62: rom_byte = 8'h53;
			63: rom_byte = 8'h44;
			64: rom_byte = 8'h52;
			65: rom_byte = 8'h41;
			66: rom_byte = 8'h4D;
			67: rom_byte = 8'h20;
			68: rom_byte = 8'h42;
			69: rom_byte = 8'h75;
			70: rom_byte = 8'h73;
			71: rom_byte = 8'h79;
			72: rom_byte = 8'h20;
			73: rom_byte = 8'h43;
			74: rom_byte = 8'h68;
			75: rom_byte = 8'h65;
			76: rom_byte = 8'h63;
			77: rom_byte = 8'h6B;
			78: rom_byte = 8'h20;
			79: rom_byte = 8'h2E;
			80: rom_byte = 8'h2E;
			81: rom_byte = 8'h2E;
			82: rom_byte = 8'h20;
			83: rom_byte = 8'h00;
			84: rom_byte = 8'h4F;
			85: rom_byte = 8'h4B;
			86: rom_byte = 8'h0D;
			87: rom_byte = 8'h0A;
			88: rom_byte = 8'h00;
			// console key wait and string print routines
			89: rom_byte = 8'hCD;
			90: rom_byte = 8'h68;
			91: rom_byte = 8'h00;
			92: rom_byte = 8'hE6;
			93: rom_byte = 8'h01;
			94: rom_byte = 8'h20;
			95: rom_byte = 8'hF9;
			96: rom_byte = 8'hCD;
			97: rom_byte = 8'h68;
			98: rom_byte = 8'h00;
			99: rom_byte = 8'hE6;
			100: rom_byte = 8'h01;
			101: rom_byte = 8'h28;
			102: rom_byte = 8'hF9;
			103: rom_byte = 8'hC9;
			104: rom_byte = 8'hDB;
			105: rom_byte = 8'h10;
			106: rom_byte = 8'hC9;
			107: rom_byte = 8'hF5;
			108: rom_byte = 8'h1A;
			109: rom_byte = 8'h13;
			110: rom_byte = 8'hB7;
			111: rom_byte = 8'h28;
			112: rom_byte = 8'h04;
			113: rom_byte = 8'hD3;
			114: rom_byte = 8'h10;
			115: rom_byte = 8'h18;
			116: rom_byte = 8'hF7;
			117: rom_byte = 8'hF1;
			118: rom_byte = 8'hC9;
			default: rom_byte = '0;
		endcase
	endfunction

	assign rd_hit = bus_valid && bus_memreq && !bus_write
		&& (bus_address[ddr3_test_pkg::ADDR_W-1:ddr3_test_pkg::TAG_LSB]
		== ddr3_test_pkg::ROM_BASE_TAG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rom_rdata <= '0;
			rom_rdata_en <= 1'b0;
		end else if (rd_hit) begin
			rom_rdata <= rom_byte(bus_address[ddr3_test_pkg::TAG_LSB-1:0]);
			rom_rdata_en <= 1'b1;
		end else begin
			rom_rdata <= '0;
			rom_rdata_en <= 1'b0;
		end
	end

	// the decode needs known request controls whenever the bus is valid
	a_req_known: assert property (@(posedge clk) disable iff (!reset_n)
		bus_valid |-> !$isunknown({bus_memreq, bus_write, bus_address}));

endmodule

// File: sim/tb_ddr3_test.sv
// testbench for the memory-test bus subsystem
// drives the bus in place of the processor and checks ROM, RAM, console and init status
`timescale 1ns/10ps

module tb_ddr3_test;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int RAM_WRITES = 40;
	localparam int ROM_CHECKS = 12;
	// worst-case length of all tests in cycles
	// the init poll may take up to 2 * INIT_CYCLES reads of two cycles each
	localparam int TEST_CYCLES = RESET_CYCLES + 2
		+ (2 + 4 * ddr3_test_pkg::INIT_CYCLES + 6)
		+ 2 * ROM_CHECKS + 4 * RAM_WRITES + 6 + 16 + 2;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
	localparam logic [15:0] LFSR_SEED = 16'd26;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	// boot image bytes, the last two addresses lie past the program
	localparam logic [15:0] ROM_ADDRS [ROM_CHECKS] = '{16'd0, 16'd1, 16'd2, 16'd3,
		16'd36, 16'd37, 16'd38, 16'd39, 16'd40, 16'd118, 16'd200, 16'h1FFF};
	localparam logic [7:0] ROM_BYTES [ROM_CHECKS] = '{8'hF3, 8'h31, 8'h00, 8'h40,
		8'h44, 8'h44, 8'h52, 8'h33, 8'h2D, 8'hC9, 8'h00, 8'h00};

	logic        reset_n;
	logic        clk;
	logic [15:0] bus_address;
	logic        bus_memreq;
	logic        bus_valid;
	logic        bus_write;
	logic [7:0]  bus_wdata;
	logic [7:0]  con_rx_data;
	logic        con_rx_valid;
	logic        bus_ready;
	logic [7:0]  bus_rdata;
	logic        bus_rdata_en;
	logic [7:0]  con_tx_data;
	logic        con_tx_valid;

	int          errors = 0;
	int          cycle_count = 0;
	int          since_release = 0;
	logic [15:0] lfsr_state;
	logic [7:0]  shadow [0:8191];
	logic [15:0] ram_addrs [0:RAM_WRITES-1];

	ddr3_test_top ddr3_test_top_inst (
		.reset_n      (reset_n),
		.clk          (clk),
		.bus_address  (bus_address),
		.bus_memreq   (bus_memreq),
		.bus_valid    (bus_valid),
		.bus_write    (bus_write),
		.bus_wdata    (bus_wdata),
		.con_rx_data  (con_rx_data),
		.con_rx_valid (con_rx_valid),
		.bus_ready    (bus_ready),
		.bus_rdata    (bus_rdata),
		.bus_rdata_en (bus_rdata_en),
		.con_tx_data  (con_tx_data),
		.con_tx_valid (con_tx_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		// mirrors the DUT, which counts from the first edge that sees reset_n high
		if (reset_n) begin
			since_release <= since_release + 1;
		end
	end

	always @(posedge clk) begin
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	always @(negedge clk) begin
		check_equal("bus_ready", 32'(bus_ready), 1);
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic drive_request(input logic memreq, input logic write,
		input logic [15:0] addr, input logic [7:0] wdata);
		bus_valid <= 1'b1;
		bus_memreq <= memreq;
		bus_write <= write;
		bus_address <= addr;
		bus_wdata <= wdata;
	endtask

	task automatic drive_idle();
		bus_valid <= 1'b0;
		bus_write <= 1'b0;
	endtask

	// one-cycle request, then the return is sampled mid-cycle after the response edge
	task automatic issue_read(input logic memreq, input logic [15:0] addr,
		output logic en, output logic [7:0] data);
		@(posedge clk);
		drive_request(memreq, 1'b0, addr, 8'h00);
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		en = bus_rdata_en;
		data = bus_rdata;
	endtask

	task automatic read_check(input logic memreq, input logic [15:0] addr,
		input logic [7:0] exp);
		logic       en;
		logic [7:0] data;
		issue_read(memreq, addr, en, data);
		check_equal($sformatf("rdata_en for 0x%04h", addr), 32'(en), 1);
		check_equal($sformatf("rdata for 0x%04h", addr), 32'(data), 32'(exp));
	endtask

	task automatic mem_read(input logic [15:0] addr, input logic [7:0] exp);
		read_check(1'b1, addr, exp);
	endtask

	task automatic io_read(input logic [7:0] port, input logic [7:0] exp);
		read_check(1'b0, {8'h00, port}, exp);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		drive_request(1'b1, 1'b1, addr, data);
		@(posedge clk);
		drive_idle();
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk);
		drive_request(1'b0, 1'b1, {8'h00, port}, data);
		@(posedge clk);
		drive_idle();
	endtask

	// second read is presented while the first is in flight
	task automatic mem_read_pair(input logic [15:0] a0, input logic [7:0] e0,
		input logic [15:0] a1, input logic [7:0] e1);
		@(posedge clk);
		drive_request(1'b1, 1'b0, a0, 8'h00);
		@(posedge clk);
		drive_request(1'b1, 1'b0, a1, 8'h00);
		@(negedge clk);
		check_equal("first of pair rdata_en", 32'(bus_rdata_en), 1);
		check_equal($sformatf("rdata for 0x%04h", a0), 32'(bus_rdata), 32'(e0));
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		check_equal("second of pair rdata_en", 32'(bus_rdata_en), 1);
		check_equal($sformatf("rdata for 0x%04h", a1), 32'(bus_rdata), 32'(e1));
	endtask

	task automatic read_unmapped(input logic memreq, input logic [15:0] addr);
		@(posedge clk);
		drive_request(memreq, 1'b0, addr, 8'h00);
		@(posedge clk);
		drive_idle();
		repeat (2) begin
			@(negedge clk);
			check_equal($sformatf("rdata_en for unmapped 0x%04h", addr), 32'(bus_rdata_en), 0);
			check_equal($sformatf("rdata for unmapped 0x%04h", addr), 32'(bus_rdata), 0);
		end
	endtask

	task automatic rx_strobe(input logic [7:0] data);
		@(posedge clk);
		con_rx_valid <= 1'b1;
		con_rx_data <= data;
		@(posedge clk);
		con_rx_valid <= 1'b0;
	endtask

	task automatic test_reset_idle();
		repeat (2) begin
			@(negedge clk);
			check_equal("bus_rdata_en after reset", 32'(bus_rdata_en), 0);
			check_equal("con_tx_valid after reset", 32'(con_tx_valid), 0);
		end
	endtask

	task automatic test_init_status();
		logic       en;
		logic [7:0] data;
		int         polls;
		io_read(ddr3_test_pkg::PORT_INIT_STAT, 8'd1);
		polls = 0;
		data = 8'd1;
		while (data != 8'd0 && polls < 2 * ddr3_test_pkg::INIT_CYCLES) begin
			issue_read(1'b0, {8'h00, ddr3_test_pkg::PORT_INIT_STAT}, en, data);
			check_equal("init poll rdata_en", 32'(en), 1);
			polls++;
		end
		check_equal("init done in time",
			32'(since_release <= ddr3_test_pkg::INIT_CYCLES + 4), 1);
		repeat (3) io_read(ddr3_test_pkg::PORT_INIT_STAT, 8'd0);
	endtask

	task automatic test_rom();
		for (int i = 0; i < ROM_CHECKS; i++) begin
			mem_read(ROM_ADDRS[i], ROM_BYTES[i]);
		end
	endtask

	task automatic test_ram();
		logic [15:0] offset;
		logic [15:0] data;
		for (int i = 0; i < RAM_WRITES; i++) begin
			draw_bits(13, offset);
			draw_bits(8, data);
			ram_addrs[i] = 16'h4000 | offset;
			shadow[offset[12:0]] = data[7:0];
			mem_write(ram_addrs[i], data[7:0]);
		end
		for (int i = 0; i < RAM_WRITES / 2; i++) begin
			mem_read(ram_addrs[i], shadow[ram_addrs[i][12:0]]);
		end
		for (int i = RAM_WRITES / 2; i < RAM_WRITES; i += 2) begin
			mem_read_pair(ram_addrs[i], shadow[ram_addrs[i][12:0]],
				ram_addrs[i+1], shadow[ram_addrs[i+1][12:0]]);
		end
	endtask

	task automatic test_unmapped();
		read_unmapped(1'b1, 16'h8000);
		read_unmapped(1'b0, 16'h0020);
	endtask

	task automatic test_console();
		io_write(ddr3_test_pkg::PORT_CON_DATA, 8'h5A);
		@(negedge clk);
		check_equal("con_tx_valid pulse", 32'(con_tx_valid), 1);
		check_equal("con_tx_data", 32'(con_tx_data), 32'h5A);
		@(negedge clk);
		check_equal("con_tx_valid after pulse", 32'(con_tx_valid), 0);
		io_read(ddr3_test_pkg::PORT_CON_STAT, 8'h00);
		rx_strobe(8'hC3);
		io_read(ddr3_test_pkg::PORT_CON_STAT, 8'h01);
		io_read(ddr3_test_pkg::PORT_CON_DATA, 8'hC3);
		io_read(ddr3_test_pkg::PORT_CON_STAT, 8'h00);
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		bus_address = '0;
		bus_memreq = 1'b0;
		bus_valid = 1'b0;
		bus_write = 1'b0;
		bus_wdata = '0;
		con_rx_data = '0;
		con_rx_valid = 1'b0;
		lfsr_state = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;

		test_reset_idle();
		test_init_status();
		test_rom();
		test_ram();
		test_unmapped();
		test_console();

		repeat (2) @(posedge clk);
		$display("All tests done after %0d cycles with %0d errors", cycle_count, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
